// ==== Bender.yml ====
package:
  name: cosh_accel

sources:
  # Packages first, the control package uses the number formats
  - logic/cosh_fixed_pkg.sv
  - logic/cosh_ctrl_pkg.sv
  # Datapath and control
  - logic/scalar_cosh_unit.sv
  - logic/vector_cosh_engine.sv
  - logic/matrix_cosh_sequencer.sv
  - logic/apb_cosh_regs.sv
  - logic/cosh_accel_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/cosh_accel_tb.sv

// ==== filelist.f ====
logic/cosh_fixed_pkg.sv
logic/cosh_ctrl_pkg.sv
logic/scalar_cosh_unit.sv
logic/vector_cosh_engine.sv
logic/matrix_cosh_sequencer.sv
logic/apb_cosh_regs.sv
logic/cosh_accel_top.sv
sim/cosh_accel_tb.sv

// ==== logic/apb_cosh_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_cosh_regs #(
  parameter int DIM_W = 8
) (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire cosh_ctrl_pkg::apb_req_t apb_req,
  output cosh_ctrl_pkg::apb_rsp_t      apb_rsp,
  input  wire logic                    busy,
  input  wire logic                    done,
  input  wire logic                    result_valid,
  output logic                         run_start,
  output logic [DIM_W-1:0]             size_i,
  output logic [DIM_W-1:0]             size_j
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic access;
  logic wr_en;
  logic busy_any;

  // Address decode
  logic addr_ok;
  logic addr_locked;
  logic err;
  logic [31:0] rdata;

  logic [DIM_W-1:0] size_i_q;
  logic [DIM_W-1:0] size_j_q;
  logic             run_start_q;
  logic             done_q;
  logic [31:0]      count_q;

  assign access   = apb_req.psel && apb_req.penable;
  assign wr_en    = access && apb_req.pwrite;
  // Busy already in the cycle of the start pulse
  assign busy_any = busy || run_start_q;

  always_comb begin
    addr_ok     = 1'b1;
    addr_locked = 1'b0;
    rdata       = '0;
    case (apb_req.paddr)
      cosh_ctrl_pkg::ADDR_CTRL: begin
        addr_locked = 1'b1;
      end
      cosh_ctrl_pkg::ADDR_STATUS: begin
        rdata = {30'd0, done_q || done, busy_any};
      end
      cosh_ctrl_pkg::ADDR_SIZE_I: begin
        addr_locked = 1'b1;
        rdata       = 32'(size_i_q);
      end
      cosh_ctrl_pkg::ADDR_SIZE_J: begin
        addr_locked = 1'b1;
        rdata       = 32'(size_j_q);
      end
      cosh_ctrl_pkg::ADDR_COUNT: begin
        rdata = count_q;
      end
      default: begin
        addr_ok = 1'b0;
      end
    endcase
  end

  // Unmapped, or config write during a run
  assign err = !addr_ok || (apb_req.pwrite && addr_locked && busy_any);

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_i_q    <= '0;
      size_j_q    <= '0;
      run_start_q <= 1'b0;
      done_q      <= 1'b0;
      count_q     <= '0;
    end else begin
      run_start_q <= 1'b0;
      if (wr_en && !err) begin
        case (apb_req.paddr)
          cosh_ctrl_pkg::ADDR_CTRL:   run_start_q <= apb_req.pwdata[0];
          cosh_ctrl_pkg::ADDR_SIZE_I: size_i_q    <= apb_req.pwdata[DIM_W-1:0];
          cosh_ctrl_pkg::ADDR_SIZE_J: size_j_q    <= apb_req.pwdata[DIM_W-1:0];
          default: begin
          end
        endcase
      end
      // Sticky done and result count, cleared by a new run
      if (run_start_q) begin
        done_q  <= 1'b0;
        count_q <= '0;
      end else begin
        if (done) begin
          done_q <= 1'b1;
        end
        if (result_valid) begin
          count_q <= count_q + 32'd1;
        end
      end
    end
  end

  // No wait states
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access && err;
  assign apb_rsp.prdata  = rdata;

  assign run_start = run_start_q;
  assign size_i    = size_i_q;
  assign size_j    = size_j_q;

  // Access phase always follows a setup phase
  a_apb_setup: assert property (@(posedge CLK) disable iff (RST)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

// ==== logic/cosh_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cosh_accel_top #(
  parameter int DIM_W = 8,
  parameter int TERMS = 5
) (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire cosh_ctrl_pkg::apb_req_t apb_req,
  output cosh_ctrl_pkg::apb_rsp_t      apb_rsp,
  input  wire cosh_ctrl_pkg::elem_in_t elem_in,
  output logic                         elem_in_ready,
  output cosh_ctrl_pkg::elem_out_t     elem_out
);

  //////////////////////////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////////////////////////

  // Registers to sequencer
  logic             run_start;
  logic [DIM_W-1:0] size_i;
  logic [DIM_W-1:0] size_j;
  logic             busy;
  logic             done;

  // Sequencer to engine
  logic row_start;
  logic final_row;
  logic row_done;

  apb_cosh_regs #(
    .DIM_W (DIM_W)
  ) u_regs (
    .CLK          (CLK),
    .RST          (RST),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .busy         (busy),
    .done         (done),
    .result_valid (elem_out.valid),
    .run_start    (run_start),
    .size_i       (size_i),
    .size_j       (size_j)
  );

  matrix_cosh_sequencer #(
    .DIM_W (DIM_W)
  ) u_seq (
    .CLK       (CLK),
    .RST       (RST),
    .run_start (run_start),
    .size_i    (size_i),
    .size_j    (size_j),
    .row_done  (row_done),
    .row_start (row_start),
    .final_row (final_row),
    .busy      (busy),
    .done      (done)
  );

  vector_cosh_engine #(
    .DIM_W (DIM_W),
    .TERMS (TERMS)
  ) u_engine (
    .CLK           (CLK),
    .RST           (RST),
    .row_start     (row_start),
    .final_row     (final_row),
    .size_j        (size_j),
    .elem_in       (elem_in),
    .elem_in_ready (elem_in_ready),
    .elem_out      (elem_out),
    .row_done      (row_done)
  );

endmodule

`default_nettype wire

// ==== logic/cosh_ctrl_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Control side: APB map, stream structs, FSM states
//////////////////////////////////////////////////////////////////////

package cosh_ctrl_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // Register offsets
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_SIZE_I = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_SIZE_J = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_COUNT  = 8'h10;

  // APB request, master to slave
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // APB response, slave to master
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Input element stream
  typedef struct packed {
    logic                  valid;
    cosh_fixed_pkg::elem_t data;
  } elem_in_t;

  // Output result stream, tagged
  typedef struct packed {
    logic                 valid;
    cosh_fixed_pkg::res_t data;
    logic                 row_last;
    logic                 mat_last;
  } elem_out_t;

  // Literal names carry a prefix, the three machines share this scope
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ROW_START,
    SEQ_ROW_WAIT,
    SEQ_FINISH
  } seq_state_e;

  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_FETCH,
    VEC_COMPUTE
  } vec_state_e;

  typedef enum logic [2:0] {
    COSH_IDLE,
    COSH_SQUARE,
    COSH_MUL_X2,
    COSH_MUL_RECIP,
    COSH_DONE
  } cosh_state_e;

endpackage

`default_nettype wire

// ==== logic/cosh_fixed_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Number formats of the cosh datapath
//////////////////////////////////////////////////////////////////////

package cosh_fixed_pkg;

  // Input element, signed Q4.12
  localparam int DATA_W = 16;

  // Result, unsigned Q20.12
  localparam int RES_W = 32;

  // Width of every intermediate product and sum
  localparam int ACC_W = 48;

  // Fraction bits shared by input, square, terms and result
  localparam int FRAC_BITS = 12;

  // 1.0 in Q.12, the zeroth series term
  localparam int ONE_Q = 4096;

  // Longest series the table supports
  localparam int MAX_TERMS = 5;

  // Reciprocal constants, scaled by 2^16
  localparam int RECIP_W     = 16;
  localparam int RECIP_SHIFT = 16;

  // Entry k-1 holds 1/((2k-1)*2k) for term k
  // 1/2, 1/12, 1/30, 1/56
  localparam logic [MAX_TERMS-2:0][RECIP_W-1:0] RECIP = {
    16'd1170,
    16'd2184,
    16'd5461,
    16'd32768
  };

  // Element and result types
  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic        [RES_W-1:0]  res_t;

endpackage

`default_nettype wire

// ==== logic/matrix_cosh_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_cosh_sequencer #(
  parameter int DIM_W = 8
) (
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic             run_start,
  input  wire logic [DIM_W-1:0] size_i,
  input  wire logic [DIM_W-1:0] size_j,
  input  wire logic             row_done,
  output logic                  row_start,
  output logic                  final_row,
  output logic                  busy,
  output logic                  done
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  cosh_ctrl_pkg::seq_state_e state_q;

  // Row index
  logic [DIM_W-1:0] row_q;
  logic             last_row;
  logic             done_q;

  assign last_row = (row_q == size_i - DIM_W'(1));

  //////////////////////////////////////////////////////////////////////
  // Row loop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= cosh_ctrl_pkg::SEQ_IDLE;
      row_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        cosh_ctrl_pkg::SEQ_IDLE: begin
          if (run_start) begin
            row_q <= '0;
            // Empty matrix, nothing to stream
            if (size_i == '0 || size_j == '0) begin
              state_q <= cosh_ctrl_pkg::SEQ_FINISH;
            end else begin
              state_q <= cosh_ctrl_pkg::SEQ_ROW_START;
            end
          end
        end
        // One cycle, row_start high
        cosh_ctrl_pkg::SEQ_ROW_START: begin
          state_q <= cosh_ctrl_pkg::SEQ_ROW_WAIT;
        end
        cosh_ctrl_pkg::SEQ_ROW_WAIT: begin
          if (row_done) begin
            if (last_row) begin
              state_q <= cosh_ctrl_pkg::SEQ_FINISH;
            end else begin
              row_q   <= row_q + DIM_W'(1);
              state_q <= cosh_ctrl_pkg::SEQ_ROW_START;
            end
          end
        end
        cosh_ctrl_pkg::SEQ_FINISH: begin
          done_q  <= 1'b1;
          state_q <= cosh_ctrl_pkg::SEQ_IDLE;
        end
        default: begin
          state_q <= cosh_ctrl_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  assign row_start = (state_q == cosh_ctrl_pkg::SEQ_ROW_START);
  assign final_row = last_row;
  assign busy      = (state_q != cosh_ctrl_pkg::SEQ_IDLE);
  assign done      = done_q;

  // Engine finishes a row only after this sequencer issued it
  a_row_done_wait: assert property (@(posedge CLK) disable iff (RST)
    row_done |-> state_q == cosh_ctrl_pkg::SEQ_ROW_WAIT);

endmodule

`default_nettype wire

// ==== logic/scalar_cosh_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module scalar_cosh_unit #(
  parameter int TERMS = 5
) (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire cosh_fixed_pkg::elem_t x,
  output logic                       done,
  output cosh_fixed_pkg::res_t       result
);

  localparam int ACC_W  = cosh_fixed_pkg::ACC_W;
  localparam int DATA_W = cosh_fixed_pkg::DATA_W;
  localparam int FRAC   = cosh_fixed_pkg::FRAC_BITS;
  localparam int KW     = $clog2(cosh_fixed_pkg::MAX_TERMS);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  cosh_ctrl_pkg::cosh_state_e state_q;

  // Index of the term being built
  logic [KW-1:0] k_q;

  cosh_fixed_pkg::elem_t x_q;

  // Square, last term, partial product, running sum
  logic [ACC_W-1:0] sq_q;
  logic [ACC_W-1:0] term_q;
  logic [ACC_W-1:0] prod_q;
  logic [ACC_W-1:0] acc_q;

  logic signed [ACC_W-1:0] x_ext;
  logic signed [ACC_W-1:0] sq_full;
  logic        [ACC_W-1:0] next_term;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////////////////////////

  // Sign extend before squaring
  assign x_ext   = {{(ACC_W-DATA_W){x_q[DATA_W-1]}}, x_q};
  assign sq_full = x_ext * x_ext;

  // Term k from the partial product and its reciprocal
  assign next_term = (prod_q * ACC_W'(cosh_fixed_pkg::RECIP[k_q - KW'(1)]))
                     >> cosh_fixed_pkg::RECIP_SHIFT;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= cosh_ctrl_pkg::COSH_IDLE;
      k_q     <= '0;
    end else begin
      case (state_q)
        cosh_ctrl_pkg::COSH_IDLE: begin
          if (start) begin
            state_q <= cosh_ctrl_pkg::COSH_SQUARE;
          end
        end
        // First partial product is the square itself, term 0 is 1.0
        cosh_ctrl_pkg::COSH_SQUARE: begin
          k_q     <= KW'(1);
          state_q <= cosh_ctrl_pkg::COSH_MUL_RECIP;
        end
        cosh_ctrl_pkg::COSH_MUL_X2: begin
          state_q <= cosh_ctrl_pkg::COSH_MUL_RECIP;
        end
        cosh_ctrl_pkg::COSH_MUL_RECIP: begin
          if (k_q == KW'(TERMS - 1)) begin
            state_q <= cosh_ctrl_pkg::COSH_DONE;
          end else begin
            k_q     <= k_q + KW'(1);
            state_q <= cosh_ctrl_pkg::COSH_MUL_X2;
          end
        end
        cosh_ctrl_pkg::COSH_DONE: begin
          state_q <= cosh_ctrl_pkg::COSH_IDLE;
        end
        default: begin
          state_q <= cosh_ctrl_pkg::COSH_IDLE;
        end
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    case (state_q)
      cosh_ctrl_pkg::COSH_IDLE: begin
        if (start) begin
          x_q <= x;
        end
      end
      cosh_ctrl_pkg::COSH_SQUARE: begin
        sq_q   <= sq_full >>> FRAC;
        prod_q <= sq_full >>> FRAC;
        term_q <= ACC_W'(cosh_fixed_pkg::ONE_Q);
        acc_q  <= ACC_W'(cosh_fixed_pkg::ONE_Q);
      end
      cosh_ctrl_pkg::COSH_MUL_X2: begin
        prod_q <= (term_q * sq_q) >> FRAC;
      end
      cosh_ctrl_pkg::COSH_MUL_RECIP: begin
        term_q <= next_term;
        acc_q  <= acc_q + next_term;
      end
      default: begin
      end
    endcase
  end

  assign done   = (state_q == cosh_ctrl_pkg::COSH_DONE);
  assign result = acc_q[cosh_fixed_pkg::RES_W-1:0];

  // Engine must wait for done before the next element
  a_start_in_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> state_q == cosh_ctrl_pkg::COSH_IDLE);

endmodule

`default_nettype wire

// ==== logic/vector_cosh_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_cosh_engine #(
  parameter int DIM_W = 8,
  parameter int TERMS = 5
) (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire logic                    row_start,
  input  wire logic                    final_row,
  input  wire logic [DIM_W-1:0]        size_j,
  input  wire cosh_ctrl_pkg::elem_in_t elem_in,
  output logic                         elem_in_ready,
  output cosh_ctrl_pkg::elem_out_t     elem_out,
  output logic                         row_done
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  cosh_ctrl_pkg::vec_state_e state_q;

  // Column index, final row flag of this row
  logic [DIM_W-1:0] col_q;
  logic             final_q;
  logic             last_col;

  // Scalar unit handshake
  logic                  cosh_start_q;
  cosh_fixed_pkg::elem_t x_q;
  logic                  cosh_done;
  cosh_fixed_pkg::res_t  cosh_result;

  // Output stream
  logic                 out_valid_q;
  logic                 row_done_q;
  cosh_fixed_pkg::res_t out_data_q;
  logic                 out_row_last_q;
  logic                 out_mat_last_q;

  assign last_col = (col_q == size_j - DIM_W'(1));

  //////////////////////////////////////////////////////////////////////
  // Column loop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= cosh_ctrl_pkg::VEC_IDLE;
      col_q        <= '0;
      final_q      <= 1'b0;
      cosh_start_q <= 1'b0;
      out_valid_q  <= 1'b0;
      row_done_q   <= 1'b0;
    end else begin
      // Pulses
      cosh_start_q <= 1'b0;
      out_valid_q  <= 1'b0;
      row_done_q   <= 1'b0;
      case (state_q)
        cosh_ctrl_pkg::VEC_IDLE: begin
          if (row_start) begin
            col_q   <= '0;
            final_q <= final_row;
            state_q <= cosh_ctrl_pkg::VEC_FETCH;
          end
        end
        // Wait here through input gaps
        cosh_ctrl_pkg::VEC_FETCH: begin
          if (elem_in.valid) begin
            cosh_start_q <= 1'b1;
            state_q      <= cosh_ctrl_pkg::VEC_COMPUTE;
          end
        end
        cosh_ctrl_pkg::VEC_COMPUTE: begin
          if (cosh_done) begin
            out_valid_q <= 1'b1;
            if (last_col) begin
              row_done_q <= 1'b1;
              state_q    <= cosh_ctrl_pkg::VEC_IDLE;
            end else begin
              col_q   <= col_q + DIM_W'(1);
              state_q <= cosh_ctrl_pkg::VEC_FETCH;
            end
          end
        end
        default: begin
          state_q <= cosh_ctrl_pkg::VEC_IDLE;
        end
      endcase
    end
  end

  // Element and result payload
  always_ff @(posedge CLK) begin
    if (elem_in_ready && elem_in.valid) begin
      x_q <= elem_in.data;
    end
    if (state_q == cosh_ctrl_pkg::VEC_COMPUTE && cosh_done) begin
      out_data_q     <= cosh_result;
      out_row_last_q <= last_col;
      out_mat_last_q <= last_col && final_q;
    end
  end

  scalar_cosh_unit #(
    .TERMS (TERMS)
  ) u_cosh (
    .CLK    (CLK),
    .RST    (RST),
    .start  (cosh_start_q),
    .x      (x_q),
    .done   (cosh_done),
    .result (cosh_result)
  );

  assign elem_in_ready     = (state_q == cosh_ctrl_pkg::VEC_FETCH);
  assign elem_out.valid    = out_valid_q;
  assign elem_out.data     = out_data_q;
  assign elem_out.row_last = out_row_last_q;
  assign elem_out.mat_last = out_mat_last_q;
  assign row_done          = row_done_q;

  // Sequencer waits for row_done before the next row
  a_row_start_idle: assert property (@(posedge CLK) disable iff (RST)
    row_start |-> state_q == cosh_ctrl_pkg::VEC_IDLE);

endmodule

`default_nettype wire

// ==== sim/cosh_accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cosh_accel_tb;

  localparam int DIM_W      = 8;
  localparam int TERMS      = 5;
  localparam int CLK_PERIOD = 40;
  localparam int MAX_GAP    = 3;

  // Two 3x4 runs plus an empty run and a 1x3 run
  localparam int TOTAL_ELEMS = 12 + 12 + 0 + 3;
  localparam int MARGIN_NS   = 1000 * CLK_PERIOD;
  localparam int WATCHDOG_NS =
    TOTAL_ELEMS * (2 * TERMS + 1 + MAX_GAP) * CLK_PERIOD + MARGIN_NS;

  //////////////////////////////////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////////////////////////////////

  logic CLK = 1'b0;
  logic RST;

  cosh_ctrl_pkg::apb_req_t  apb_req;
  cosh_ctrl_pkg::apb_rsp_t  apb_rsp;
  cosh_ctrl_pkg::elem_in_t  elem_in;
  logic                     elem_in_ready;
  cosh_ctrl_pkg::elem_out_t elem_out;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  cosh_accel_top #(
    .DIM_W (DIM_W),
    .TERMS (TERMS)
  ) dut0 (
    .CLK           (CLK),
    .RST           (RST),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .elem_in       (elem_in),
    .elem_in_ready (elem_in_ready),
    .elem_out      (elem_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Scoreboard state
  //////////////////////////////////////////////////////////////////////

  integer seed = 11;
  int     errors = 0;
  string  test_name = "reset";

  // Expected results kept in output order
  cosh_ctrl_pkg::elem_out_t exp_q[$];
  cosh_fixed_pkg::elem_t    stim_q[$];

  // Index of the next output and head of the expected list
  int                       out_idx;
  cosh_ctrl_pkg::elem_out_t exp_head;
  logic                     exp_have;

  // Error response the current APB access should get
  logic err_expect = 1'b0;

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_idx <= 0;
    end else if (elem_out.valid) begin
      out_idx <= out_idx + 1;
    end
  end

  // Stable across the rising edge
  always @(negedge CLK) begin
    if (out_idx < exp_q.size()) begin
      exp_head = exp_q[out_idx];
      exp_have = 1'b1;
    end else begin
      exp_head = '0;
      exp_have = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [47:0] recip_of(input int k);
    case (k)
      1:       return 48'd32768;
      2:       return 48'd5461;
      3:       return 48'd2184;
      default: return 48'd1170;
    endcase
  endfunction

  // Taylor series with truncating shifts after every product
  function automatic cosh_fixed_pkg::res_t cosh_model(input cosh_fixed_pkg::elem_t x);
    logic signed [47:0] xs;
    logic        [47:0] sq;
    logic        [47:0] term;
    logic        [47:0] prod;
    logic        [47:0] sum;
    int                 k;
    xs   = x;
    sq   = (xs * xs) >>> 12;
    term = 48'd4096;
    sum  = 48'd4096;
    for (k = 1; k < TERMS; k++) begin
      prod = (term * sq) >> 12;
      term = (prod * recip_of(k)) >> 16;
      sum  = sum + term;
    end
    return sum[31:0];
  endfunction

  task automatic expect_result(input cosh_fixed_pkg::res_t data, input logic row_last,
                               input logic mat_last);
    cosh_ctrl_pkg::elem_out_t e;
    e.valid    = 1'b1;
    e.data     = data;
    e.row_last = row_last;
    e.mat_last = mat_last;
    exp_q.push_back(e);
  endtask

  // Random matrix in +-4.0 filled row by row
  task automatic fill_random(input int rows, input int cols);
    int                    r;
    int                    c;
    cosh_fixed_pkg::elem_t x;
    for (r = 0; r < rows; r++) begin
      for (c = 0; c < cols; c++) begin
        x = cosh_fixed_pkg::elem_t'($random(seed) % 16385);
        stim_q.push_back(x);
        expect_result(cosh_model(x), c == cols - 1, (c == cols - 1) && (r == rows - 1));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB and stream drivers
  //////////////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic want_err);
    @(negedge CLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    err_expect      = want_err;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    @(negedge CLK);
    apb_req    = '0;
    err_expect = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          input logic want_err);
    @(negedge CLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    err_expect      = want_err;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    // Read data of the access cycle
    @(posedge CLK);
    data = apb_rsp.prdata;
    @(negedge CLK);
    apb_req    = '0;
    err_expect = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] rd;
    apb_read(addr, rd, 1'b0);
    assert (rd == expected) else begin
      errors++;
      $display("mismatch test %s reg 0x%02h expected 0x%08h actual 0x%08h",
               test_name, addr, expected, rd);
    end
  endtask

  // Poll STATUS until the sticky done bit shows
  task automatic wait_run_done();
    logic [31:0] rd;
    do begin
      apb_read(cosh_ctrl_pkg::ADDR_STATUS, rd, 1'b0);
    end while (!rd[1]);
  endtask

  // Random gap before each element
  // Valid held until taken
  task automatic stream_elements();
    cosh_fixed_pkg::elem_t x;
    int                    gap;
    while (stim_q.size() > 0) begin
      x   = stim_q.pop_front();
      gap = {$random(seed)} % (MAX_GAP + 1);
      repeat (gap) @(negedge CLK);
      elem_in.valid = 1'b1;
      elem_in.data  = x;
      while (!elem_in_ready) @(negedge CLK);
      // Taken at the rising edge in between
      @(negedge CLK);
      elem_in = '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_no_extra: assert property (@(posedge CLK) disable iff (RST)
    elem_out.valid |-> exp_have)
    else begin
      errors++;
      $display("test %s produced an output with no result expected", test_name);
    end

  a_value: assert property (@(posedge CLK) disable iff (RST)
    elem_out.valid && exp_have |-> elem_out.data == exp_head.data)
    else begin
      errors++;
      $display("mismatch test %s result %0d expected %0d actual %0d", test_name,
               $sampled(out_idx), $sampled(exp_head.data), $sampled(elem_out.data));
    end

  // Tags shown as {row_last, mat_last}
  a_tags: assert property (@(posedge CLK) disable iff (RST)
    elem_out.valid && exp_have |->
      elem_out.row_last == exp_head.row_last && elem_out.mat_last == exp_head.mat_last)
    else begin
      errors++;
      $display("mismatch test %s tags of result %0d expected %b%b actual %b%b", test_name,
               $sampled(out_idx), $sampled(exp_head.row_last), $sampled(exp_head.mat_last),
               $sampled(elem_out.row_last), $sampled(elem_out.mat_last));
    end

  // Fixed engine latency from element taken to result
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    elem_in.valid && elem_in_ready |-> ##(2 * TERMS + 1) elem_out.valid)
    else begin
      errors++;
      $display("test %s result did not arrive exactly %0d cycles after its input element",
               test_name, 2 * TERMS + 1);
    end

  a_pready: assert property (@(posedge CLK) disable iff (RST)
    apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else begin
      errors++;
      $display("test %s APB access without pready", test_name);
    end

  a_pslverr: assert property (@(posedge CLK) disable iff (RST)
    apb_req.psel && apb_req.penable |-> apb_rsp.pslverr == err_expect)
    else begin
      errors++;
      $display("mismatch test %s pslverr at 0x%02h expected %b actual %b", test_name,
               $sampled(apb_req.paddr), $sampled(err_expect), $sampled(apb_rsp.pslverr));
    end

  a_reset_quiet: assert property (@(posedge CLK)
    $fell(RST) |-> !elem_in_ready && !elem_out.valid && !apb_rsp.pslverr)
    else begin
      errors++;
      $display("outputs not idle after reset");
    end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    RST     = 1'b1;
    apb_req = '0;
    elem_in = '0;
    repeat (5) @(negedge CLK);
    RST = 1'b0;

    // Neither busy nor done out of reset
    check_reg(cosh_ctrl_pkg::ADDR_STATUS, 32'h0);

    // 3x4 run with busy errors along the way
    test_name = "matrix_3x4";
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_I, 32'd3, 1'b0);
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_J, 32'd4, 1'b0);
    apb_read(8'h20, rd, 1'b1);
    fill_random(3, 4);
    apb_write(cosh_ctrl_pkg::ADDR_CTRL, 32'd1, 1'b0);
    check_reg(cosh_ctrl_pkg::ADDR_STATUS, 32'h1);
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_I, 32'd7, 1'b1);
    check_reg(cosh_ctrl_pkg::ADDR_SIZE_I, 32'd3);
    stream_elements();
    wait_run_done();
    check_reg(cosh_ctrl_pkg::ADDR_COUNT, 32'd12);
    check_reg(cosh_ctrl_pkg::ADDR_STATUS, 32'h2);

    // Done and count cleared by the new start
    test_name = "second_run";
    fill_random(3, 4);
    apb_write(cosh_ctrl_pkg::ADDR_CTRL, 32'd1, 1'b0);
    check_reg(cosh_ctrl_pkg::ADDR_STATUS, 32'h1);
    check_reg(cosh_ctrl_pkg::ADDR_COUNT, 32'd0);
    stream_elements();
    wait_run_done();
    check_reg(cosh_ctrl_pkg::ADDR_COUNT, 32'd12);

    test_name = "zero_size";
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_J, 32'd0, 1'b0);
    apb_write(cosh_ctrl_pkg::ADDR_CTRL, 32'd1, 1'b0);
    wait_run_done();
    check_reg(cosh_ctrl_pkg::ADDR_COUNT, 32'd0);
    check_reg(cosh_ctrl_pkg::ADDR_STATUS, 32'h2);

    // cosh(0) is the first term alone
    // Both signs of 4.0 share one result
    test_name = "edge_values";
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_I, 32'd1, 1'b0);
    apb_write(cosh_ctrl_pkg::ADDR_SIZE_J, 32'd3, 1'b0);
    stim_q.push_back(16'sd0);
    stim_q.push_back(16'sd16384);
    stim_q.push_back(-16'sd16384);
    expect_result(32'd4096, 1'b0, 1'b0);
    expect_result(cosh_model(16'sd16384), 1'b0, 1'b0);
    expect_result(cosh_model(16'sd16384), 1'b1, 1'b1);
    apb_write(cosh_ctrl_pkg::ADDR_CTRL, 32'd1, 1'b0);
    stream_elements();
    wait_run_done();
    check_reg(cosh_ctrl_pkg::ADDR_COUNT, 32'd3);

    repeat (5) @(negedge CLK);
    assert (out_idx == exp_q.size()) else begin
      errors++;
      $display("only %0d of %0d expected results arrived", out_idx, exp_q.size());
    end
    $display("errors: %0d, results checked: %0d", errors, out_idx);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired in test %s before the run completed", test_name);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
